// File: source/soc_bus_pkg.sv
/*
  soc bus package
  address map, region codes and bus widths shared by the
  memory-side bus, its targets and the verification code
*/
`default_nettype none

package soc_bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;

  // top address byte of each region
  localparam logic [7:0] flash_start   = 8'h00;
  localparam logic [7:0] cust_ip_start = 8'h02;
  localparam logic [7:0] natv_ip_start = 8'h03;
  localparam logic [7:0] sram_start    = 8'h04;
  localparam logic [7:0] psram_start   = 8'h40;

  // read-only value of native register 0
  localparam logic [31:0] natv_id      = 32'h5243_0001;
  // answer for an access that hits no region
  localparam logic [31:0] bus_err_data = 32'hBADD_ADD0;

  typedef enum logic [2:0] {
    region_natv,
    region_mmap,
    region_sram,
    region_psram,
    region_none
  } bus_region_e;

endpackage

`default_nettype wire

// File: source/mem_req_if.sv
/*
  memory request interface
  valid/ready access channel between the decoder and one target
*/
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
  import soc_bus_pkg::*;

  logic                valid;
  logic [addr_w-1:0]   addr;
  logic [data_w-1:0]   wdata;
  logic [data_w/8-1:0] wstrb;
  logic [data_w-1:0]   rdata;
  logic                ready;

  // host holds the request fields until ready
  modport host (output valid, addr, wdata, wstrb, input rdata, ready);

  // target answers with one ready pulse per access
  modport target (input valid, addr, wdata, wstrb, output rdata, ready);

endinterface

`default_nettype wire

// File: source/bus.sv
/*
  memory-side bus decoder
  steers each core access to one target by the top address byte,
  muxes ready and read data back and answers unmapped addresses
*/
`timescale 1ns/1ps
`default_nettype none

module bus (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            core_valid_i,
  input  logic [soc_bus_pkg::addr_w-1:0]  core_addr_i,
  input  logic [soc_bus_pkg::data_w-1:0]  core_wdata_i,
  input  logic [soc_bus_pkg::data_w/8-1:0] core_wstrb_i,
  output logic [soc_bus_pkg::data_w-1:0]  core_rdata_o,
  output logic                            core_ready_o,
  mem_req_if.host                         natv_o,
  mem_req_if.host                         sram_o,
  mem_req_if.host                         psram_o,
  output logic                            mmap_valid_o,
  output logic [soc_bus_pkg::addr_w-1:0]  mmap_addr_o,
  output logic [soc_bus_pkg::data_w-1:0]  mmap_wdata_o,
  output logic [soc_bus_pkg::data_w/8-1:0] mmap_wstrb_o,
  input  logic [soc_bus_pkg::data_w-1:0]  mmap_rdata_i,
  input  logic                            mmap_ready_i
);
  import soc_bus_pkg::*;

  bus_region_e region;
  logic [7:0]  top_byte;
  logic        err_valid;
  logic        err_ready_q;
  logic        sel_ready;

  assign top_byte = core_addr_i[addr_w-1 -: 8];

  always_comb begin
    case (top_byte)
      natv_ip_start:              region = region_natv;
      flash_start, cust_ip_start: region = region_mmap;
      sram_start:                 region = region_sram;
      psram_start:                region = region_psram;
      default:                    region = region_none;
    endcase
  end

  // only the selected target sees valid
  assign natv_o.valid  = core_valid_i && (region == region_natv);
  assign sram_o.valid  = core_valid_i && (region == region_sram);
  assign psram_o.valid = core_valid_i && (region == region_psram);
  assign mmap_valid_o  = core_valid_i && (region == region_mmap);
  assign err_valid     = core_valid_i && (region == region_none);

  assign natv_o.addr   = core_addr_i;
  assign natv_o.wdata  = core_wdata_i;
  assign natv_o.wstrb  = core_wstrb_i;
  assign sram_o.addr   = core_addr_i;
  assign sram_o.wdata  = core_wdata_i;
  assign sram_o.wstrb  = core_wstrb_i;
  assign psram_o.addr  = core_addr_i;
  assign psram_o.wdata = core_wdata_i;
  assign psram_o.wstrb = core_wstrb_i;
  assign mmap_addr_o   = core_addr_i;
  assign mmap_wdata_o  = core_wdata_i;
  assign mmap_wstrb_o  = core_wstrb_i;

  // error responder gives one pulse per unmapped access
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_ready_q <= 1'b0;
    end else begin
      err_ready_q <= err_valid && !err_ready_q;
    end
  end

  always_comb begin
    case (region)
      region_natv: begin
        sel_ready    = natv_o.ready;
        core_rdata_o = natv_o.rdata;
      end
      region_mmap: begin
        sel_ready    = mmap_ready_i;
        core_rdata_o = mmap_rdata_i;
      end
      region_sram: begin
        sel_ready    = sram_o.ready;
        core_rdata_o = sram_o.rdata;
      end
      region_psram: begin
        sel_ready    = psram_o.ready;
        core_rdata_o = psram_o.rdata;
      end
      default: begin
        sel_ready    = err_ready_q;
        core_rdata_o = bus_err_data;
      end
    endcase
  end

  assign core_ready_o = sel_ready;

endmodule

`default_nettype wire

// File: source/natv_regs.sv
/*
  native peripheral registers
  ID word, two byte-writable scratch words and a counter of
  accepted writes, answered one cycle after valid
*/
`timescale 1ns/1ps
`default_nettype none

module natv_regs (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_req_if.target bus_i
);
  import soc_bus_pkg::*;

  logic [data_w-1:0] scratch1_q;
  logic [data_w-1:0] scratch2_q;
  logic [data_w-1:0] wr_cnt_q;
  logic [data_w-1:0] rdata_q;
  logic [data_w-1:0] rd_word;
  logic              ready_q;
  logic              accept;
  logic [1:0]        idx;

  assign idx = bus_i.addr[3:2];
  // taken once, in the cycle before ready rises
  assign accept = bus_i.valid && !ready_q;

  always_comb begin
    case (idx)
      2'd0:    rd_word = natv_id;
      2'd1:    rd_word = scratch1_q;
      2'd2:    rd_word = scratch2_q;
      default: rd_word = wr_cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q  <= 1'b0;
      wr_cnt_q <= '0;
    end else begin
      ready_q <= accept;
      // every native write counts, reg 3 included
      if (accept && (bus_i.wstrb != '0)) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_word;
      for (int b = 0; b < data_w / 8; b++) begin
        if (bus_i.wstrb[b] && (idx == 2'd1)) begin
          scratch1_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
        if (bus_i.wstrb[b] && (idx == 2'd2)) begin
          scratch2_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  assign bus_i.ready = ready_q;
  assign bus_i.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/sram_bank.sv
/*
  on-chip sram bank
  word array with byte strobes, answered one cycle after valid
*/
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
  parameter int unsigned sram_words = 1024
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_req_if.target bus_i
);
  import soc_bus_pkg::*;

  localparam int unsigned idx_w = (sram_words > 1) ? $clog2(sram_words) : 1;

  logic [data_w-1:0] mem_q [sram_words];
  logic [data_w-1:0] rdata_q;
  logic [idx_w-1:0]  idx;
  logic              ready_q;
  logic              accept;

  assign idx    = bus_i.addr[2 +: idx_w];
  assign accept = bus_i.valid && !ready_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  // masked write and read share the accepting edge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= mem_q[idx];
      for (int b = 0; b < data_w / 8; b++) begin
        if (bus_i.wstrb[b]) begin
          mem_q[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  assign bus_i.ready = ready_q;
  assign bus_i.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/psram_ctrl.sv
/*
  psram controller model
  latches an access, waits a fixed number of cycles for the
  command and latency phases, then completes it with one ready pulse
*/
`timescale 1ns/1ps
`default_nettype none

module psram_ctrl #(
  parameter int unsigned psram_words = 1024,
  parameter int unsigned psram_wait  = 4
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_req_if.target bus_i
);
  import soc_bus_pkg::*;

  localparam int unsigned idx_w = (psram_words > 1) ? $clog2(psram_words) : 1;
  localparam int unsigned cnt_w = (psram_wait > 1) ? $clog2(psram_wait + 1) : 1;

  typedef enum logic [1:0] {
    psram_idle,
    psram_wait_st,
    psram_done
  } psram_state_e;

  psram_state_e        state_q;
  logic [cnt_w-1:0]    cnt_q;
  logic [idx_w-1:0]    idx_q;
  logic [data_w-1:0]   wdata_q;
  logic [data_w/8-1:0] wstrb_q;
  logic [data_w-1:0]   rdata_q;
  logic [data_w-1:0]   mem_q [psram_words];
  logic                last_wait;

  assign last_wait = (cnt_q == cnt_w'(psram_wait - 1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= psram_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        psram_idle: begin
          cnt_q <= '0;
          if (bus_i.valid) begin
            state_q <= psram_wait_st;
          end
        end
        psram_wait_st: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_wait) begin
            state_q <= psram_done;
          end
        end
        // back to idle for a cycle after the answer
        default: state_q <= psram_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == psram_idle) && bus_i.valid) begin
      idx_q   <= bus_i.addr[2 +: idx_w];
      wdata_q <= bus_i.wdata;
      wstrb_q <= bus_i.wstrb;
    end
    if ((state_q == psram_wait_st) && last_wait) begin
      rdata_q <= mem_q[idx_q];
      for (int b = 0; b < data_w / 8; b++) begin
        if (wstrb_q[b]) begin
          mem_q[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  assign bus_i.ready = (state_q == psram_done);
  assign bus_i.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/bus_top.sv
/*
  memory-side bus top level
  decoder plus native registers, sram and psram targets,
  with the core and external mmap ports brought out
*/
`timescale 1ns/1ps
`default_nettype none

module bus_top #(
  parameter int unsigned sram_words  = 1024,
  parameter int unsigned psram_words = 1024,
  parameter int unsigned psram_wait  = 4
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // core port
  input  logic                             core_valid_i,
  input  logic [soc_bus_pkg::addr_w-1:0]   core_addr_i,
  input  logic [soc_bus_pkg::data_w-1:0]   core_wdata_i,
  input  logic [soc_bus_pkg::data_w/8-1:0] core_wstrb_i,
  output logic [soc_bus_pkg::data_w-1:0]   core_rdata_o,
  output logic                             core_ready_o,
  // flash and custom ip port
  output logic                             mmap_valid_o,
  output logic [soc_bus_pkg::addr_w-1:0]   mmap_addr_o,
  output logic [soc_bus_pkg::data_w-1:0]   mmap_wdata_o,
  output logic [soc_bus_pkg::data_w/8-1:0] mmap_wstrb_o,
  input  logic [soc_bus_pkg::data_w-1:0]   mmap_rdata_i,
  input  logic                             mmap_ready_i
);

  mem_req_if natv_bus ();
  mem_req_if sram_bus ();
  mem_req_if psram_bus ();

  bus bus_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .core_valid_i (core_valid_i),
    .core_addr_i  (core_addr_i),
    .core_wdata_i (core_wdata_i),
    .core_wstrb_i (core_wstrb_i),
    .core_rdata_o (core_rdata_o),
    .core_ready_o (core_ready_o),
    .natv_o       (natv_bus.host),
    .sram_o       (sram_bus.host),
    .psram_o      (psram_bus.host),
    .mmap_valid_o (mmap_valid_o),
    .mmap_addr_o  (mmap_addr_o),
    .mmap_wdata_o (mmap_wdata_o),
    .mmap_wstrb_o (mmap_wstrb_o),
    .mmap_rdata_i (mmap_rdata_i),
    .mmap_ready_i (mmap_ready_i)
  );

  natv_regs natv_regs_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (natv_bus.target)
  );

  sram_bank #(.sram_words(sram_words)) sram_bank_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (sram_bus.target)
  );

  psram_ctrl #(
    .psram_words (psram_words),
    .psram_wait  (psram_wait)
  ) psram_ctrl_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (psram_bus.target)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
/*
  testbench clock and reset
  40 ns clock, reset held low for the first 8 cycles
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/bus_props.sv
/*
  core port handshake properties
  bound into the bus top level, watching the core port
  and the forwarded target channels
*/
`timescale 1ns/1ps
`default_nettype none

module bus_props (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        core_valid_i,
  input logic [31:0] core_addr_i,
  input logic [31:0] core_wdata_i,
  input logic [3:0]  core_wstrb_i,
  input logic        core_ready_i,
  input logic        mmap_valid_i,
  input logic        natv_valid_i,
  input logic        sram_valid_i,
  input logic        psram_valid_i,
  input logic        natv_ready_i,
  input logic        sram_ready_i
);

  int fail_cnt = 0;

  // ready only ever answers a pending access
  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_ready_i |-> core_valid_i)
    else begin
      $error("core ready high without core valid");
      fail_cnt++;
    end

  // a waiting request keeps all of its fields
  req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (core_valid_i && !core_ready_i) |=> (core_valid_i && $stable(core_addr_i)
      && $stable(core_wdata_i) && $stable(core_wstrb_i)))
    else begin
      $error("core request changed before ready");
      fail_cnt++;
    end

  one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({natv_valid_i, sram_valid_i, psram_valid_i, mmap_valid_i}))
    else begin
      $error("more than one target sees valid");
      fail_cnt++;
    end

  natv_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    natv_ready_i |=> !natv_ready_i)
    else begin
      $error("native ready longer than one cycle");
      fail_cnt++;
    end

  sram_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sram_ready_i |=> !sram_ready_i)
    else begin
      $error("sram ready longer than one cycle");
      fail_cnt++;
    end

endmodule

bind bus_top bus_props props_i (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .core_valid_i  (core_valid_i),
  .core_addr_i   (core_addr_i),
  .core_wdata_i  (core_wdata_i),
  .core_wstrb_i  (core_wstrb_i),
  .core_ready_i  (core_ready_o),
  .mmap_valid_i  (mmap_valid_o),
  .natv_valid_i  (natv_bus.valid),
  .sram_valid_i  (sram_bus.valid),
  .psram_valid_i (psram_bus.valid),
  .natv_ready_i  (natv_bus.ready),
  .sram_ready_i  (sram_bus.ready)
);

`default_nettype wire

// File: verif/bus_checker.sv
/*
  core port checker
  follows each access on the core port, keeps a byte-masked
  memory model per address and compares latency and read data
*/
`timescale 1ns/1ps
`default_nettype none

module bus_checker #(
  parameter int unsigned psram_wait = 4
) (
  input  logic                             clk_i,
  input  logic                             core_valid_i,
  input  logic [soc_bus_pkg::addr_w-1:0]   core_addr_i,
  input  logic [soc_bus_pkg::data_w-1:0]   core_wdata_i,
  input  logic [soc_bus_pkg::data_w/8-1:0] core_wstrb_i,
  input  logic [soc_bus_pkg::data_w-1:0]   core_rdata_i,
  input  logic                             core_ready_i,
  input  logic                             mmap_valid_i,
  input  logic [soc_bus_pkg::addr_w-1:0]   mmap_addr_i,
  input  logic [soc_bus_pkg::data_w-1:0]   mmap_wdata_i,
  input  logic [soc_bus_pkg::data_w/8-1:0] mmap_wstrb_i,
  input  logic                             mmap_ready_i,
  output int                               err_cnt_o,
  output int                               acc_cnt_o
);
  import soc_bus_pkg::*;

  // model keyed by word address, with a mask of bytes ever written
  logic [31:0] mem_model [bit [29:0]];
  logic [3:0]  known [bit [29:0]];
  int          errors = 0;
  int          accs = 0;
  int          natv_writes = 0;
  int          cyc = 0;
  bit          busy = 1'b0;

  assign err_cnt_o = errors;
  assign acc_cnt_o = accs;

  function automatic bus_region_e region_of(input logic [31:0] addr);
    case (addr[31:24])
      natv_ip_start:              return region_natv;
      flash_start, cust_ip_start: return region_mmap;
      sram_start:                 return region_sram;
      psram_start:                return region_psram;
      default:                    return region_none;
    endcase
  endfunction

  function automatic logic [31:0] strb_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic finish_access(input bus_region_e rgn);
    bit [29:0]   key;
    logic [31:0] mask;
    int          lat;
    key = core_addr_i[31:2];
    lat = (rgn == region_psram) ? int'(psram_wait) + 2 : 2;
    accs++;
    if (rgn == region_mmap) begin
      if (cyc < 2 || cyc > 7) begin
        report_fail($sformatf("mmap access took %0d cycles, outside 2 to 7", cyc));
      end
    end else if (cyc != lat) begin
      report_fail($sformatf("%s access took %0d cycles, expected %0d",
                            rgn.name(), cyc, lat));
    end
    if (rgn == region_none) begin
      if (core_rdata_i !== bus_err_data) begin
        report_value("core_rdata_o", core_rdata_i, bus_err_data);
      end
    end else if (rgn == region_natv && key[1:0] == 2'd0) begin
      if (core_wstrb_i == '0 && core_rdata_i !== natv_id) begin
        report_value("core_rdata_o", core_rdata_i, natv_id);
      end
    end else if (rgn == region_natv && key[1:0] == 2'd3) begin
      if (core_wstrb_i == '0 && core_rdata_i !== 32'(natv_writes)) begin
        report_value("core_rdata_o", core_rdata_i, 32'(natv_writes));
      end
    end else if (core_wstrb_i == '0) begin
      // words never written are skipped, partly written ones masked
      if (known.exists(key)) begin
        mask = strb_mask(known[key]);
        if ((core_rdata_i & mask) !== (mem_model[key] & mask)) begin
          report_value("core_rdata_o", core_rdata_i & mask, mem_model[key] & mask);
        end
      end
    end else begin
      if (!known.exists(key)) begin
        known[key] = 4'h0;
        mem_model[key] = '0;
      end
      for (int b = 0; b < 4; b++) begin
        if (core_wstrb_i[b]) begin
          mem_model[key][8*b +: 8] = core_wdata_i[8*b +: 8];
        end
      end
      known[key] = known[key] | core_wstrb_i;
    end
    if (rgn == region_natv && core_wstrb_i != '0) begin
      natv_writes++;
    end
  endtask

  always @(posedge clk_i) begin
    bus_region_e rgn;
    if (!core_valid_i) begin
      if (core_ready_i !== 1'b0) begin
        report_fail("core ready high while core valid is low");
      end
      if (mmap_valid_i !== 1'b0) begin
        report_fail("mmap valid high while core valid is low");
      end
    end else begin
      rgn = region_of(core_addr_i);
      if (!busy) begin
        busy = 1'b1;
        cyc = 0;
      end
      cyc++;
      if (rgn == region_mmap) begin
        if (mmap_valid_i !== 1'b1) begin
          report_fail("mmap valid low during an external access");
        end
        if (mmap_addr_i !== core_addr_i) begin
          report_value("mmap_addr_o", mmap_addr_i, core_addr_i);
        end
        if (mmap_wdata_i !== core_wdata_i) begin
          report_value("mmap_wdata_o", mmap_wdata_i, core_wdata_i);
        end
        if (mmap_wstrb_i !== core_wstrb_i) begin
          report_value("mmap_wstrb_o", 32'(mmap_wstrb_i), 32'(core_wstrb_i));
        end
        if (core_ready_i !== mmap_ready_i) begin
          report_value("core_ready_o", 32'(core_ready_i), 32'(mmap_ready_i));
        end
      end else if (mmap_valid_i !== 1'b0) begin
        report_fail("mmap valid high for an address outside the mmap regions");
      end
      if (core_ready_i === 1'b1) begin
        finish_access(rgn);
        busy = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/bus_tb.sv
/*
  memory-side bus testbench
  random core host, external mmap responder and watchdog
  around the bus top level
*/
`timescale 1ns/1ps
`default_nettype none

module bus_tb;
  import soc_bus_pkg::*;

  localparam int unsigned num_acc         = 400;
  localparam int unsigned psram_wait      = 4;
  localparam int unsigned watchdog_cycles = num_acc * (psram_wait + 8);

  logic                clk;
  logic                arst_n;
  logic                core_valid = 1'b0;
  logic [addr_w-1:0]   core_addr  = '0;
  logic [data_w-1:0]   core_wdata = '0;
  logic [data_w/8-1:0] core_wstrb = '0;
  logic [data_w-1:0]   core_rdata;
  logic                core_ready;
  logic                mmap_valid;
  logic [addr_w-1:0]   mmap_addr;
  logic [data_w-1:0]   mmap_wdata;
  logic [data_w/8-1:0] mmap_wstrb;
  logic [data_w-1:0]   mmap_rdata = '0;
  logic                mmap_ready = 1'b0;
  logic [data_w-1:0]   ext_mem [256];
  logic [7:0]          ext_idx;
  logic                resp_busy;
  int unsigned         resp_wait;
  integer              seed = 67;
  integer              resp_seed = 67;
  int                  err_cnt;
  int                  acc_cnt;

  tb_clk_gen clk_gen_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  bus_top #(.psram_wait(psram_wait)) dut_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .core_valid_i (core_valid),
    .core_addr_i  (core_addr),
    .core_wdata_i (core_wdata),
    .core_wstrb_i (core_wstrb),
    .core_rdata_o (core_rdata),
    .core_ready_o (core_ready),
    .mmap_valid_o (mmap_valid),
    .mmap_addr_o  (mmap_addr),
    .mmap_wdata_o (mmap_wdata),
    .mmap_wstrb_o (mmap_wstrb),
    .mmap_rdata_i (mmap_rdata),
    .mmap_ready_i (mmap_ready)
  );

  bus_checker #(.psram_wait(psram_wait)) bus_checker_i (
    .clk_i        (clk),
    .core_valid_i (core_valid),
    .core_addr_i  (core_addr),
    .core_wdata_i (core_wdata),
    .core_wstrb_i (core_wstrb),
    .core_rdata_i (core_rdata),
    .core_ready_i (core_ready),
    .mmap_valid_i (mmap_valid),
    .mmap_addr_i  (mmap_addr),
    .mmap_wdata_i (mmap_wdata),
    .mmap_wstrb_i (mmap_wstrb),
    .mmap_ready_i (mmap_ready),
    .err_cnt_o    (err_cnt),
    .acc_cnt_o    (acc_cnt)
  );

  // flash and custom ip share one array, told apart by the region byte
  assign ext_idx = {mmap_addr[25:24], mmap_addr[7:2]};

  // external responder, answers 0 to 5 cycles late
  always @(posedge clk or negedge arst_n) begin
    int unsigned d;
    if (!arst_n) begin
      mmap_ready <= 1'b0;
      resp_busy  <= 1'b0;
      resp_wait  <= 0;
    end else begin
      mmap_ready <= 1'b0;
      if (mmap_valid && !mmap_ready) begin
        if (resp_busy) begin
          d = resp_wait;
        end else begin
          d = $unsigned($random(resp_seed)) % 6;
        end
        if (d == 0) begin
          mmap_ready <= 1'b1;
          resp_busy  <= 1'b0;
          mmap_rdata <= ext_mem[ext_idx];
          for (int b = 0; b < data_w / 8; b++) begin
            if (mmap_wstrb[b]) begin
              ext_mem[ext_idx][8*b +: 8] <= mmap_wdata[8*b +: 8];
            end
          end
        end else begin
          resp_busy <= 1'b1;
          resp_wait <= d - 1;
        end
      end
    end
  end

  // random host on the core port
  initial begin
    int unsigned pick;
    int unsigned offset;
    logic [7:0]  top;
    logic [3:0]  strb;
    int          total;
    @(posedge arst_n);
    @(posedge clk);
    for (int n = 0; n < int'(num_acc); n++) begin
      pick   = $unsigned($random(seed)) % 16;
      offset = $unsigned($random(seed)) % 16;
      if (pick < 4) begin
        top = sram_start;
      end else if (pick < 7) begin
        top = psram_start;
      end else if (pick < 10) begin
        top = natv_ip_start;
        offset = offset % 4;
      end else if (pick < 12) begin
        top = flash_start;
      end else if (pick < 14) begin
        top = cust_ip_start;
      end else begin
        top = 8'h80 | 8'($random(seed));
      end
      strb = 4'($random(seed));
      if ($random(seed) % 2 == 0) begin
        strb = 4'h0;
      end
      core_valid <= 1'b1;
      core_addr  <= {top, 14'h0, 8'(offset), 2'b00};
      core_wdata <= $random(seed);
      core_wstrb <= strb;
      @(posedge clk);
      while (!core_ready) begin
        @(posedge clk);
      end
      if ($random(seed) % 2 == 0) begin
        core_valid <= 1'b0;
        core_wstrb <= 4'h0;
        @(posedge clk);
      end
    end
    core_valid <= 1'b0;
    core_wstrb <= 4'h0;
    repeat (4) @(posedge clk);
    total = err_cnt + dut_i.props_i.fail_cnt;
    if (acc_cnt != int'(num_acc)) begin
      $display("checker saw %0d completed accesses instead of %0d", acc_cnt, num_acc);
      total++;
    end
    $display("accesses %0d, checker errors %0d, assertion failures %0d",
             acc_cnt, err_cnt, dut_i.props_i.fail_cnt);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: host did not finish within %0d cycles", watchdog_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
source/soc_bus_pkg.sv
source/mem_req_if.sv
source/bus.sv
source/natv_regs.sv
source/sram_bank.sv
source/psram_ctrl.sv
source/bus_top.sv
verif/tb_clk_gen.sv
verif/bus_props.sv
verif/bus_checker.sv
verif/bus_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module bus_tb -f all.f -o bus_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# let assertion failures be counted by the testbench instead of stopping the run
out=$(./obj_dir/bus_sim +verilator+error+limit+100000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
fi
exit 1
